//--- hdl/fetch_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage shared definitions
// Address width, reset vector, fetch FSM states and the
// saturating counter geometry of the branch target buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fetch_pkg;

	// Address and instruction word width
	localparam int ADDR_W = 32;

	localparam logic [ADDR_W-1:0] RESET_PC = '0; // First fetch after reset

	// Fetch FSM
	typedef enum logic [1:0] {
		FS_START = 2'd0,	// One cycle after reset
		FS_FETCH = 2'd1,	// Issuing requests
		FS_HALT  = 2'd2		// Stopped by exception, waits for redirect
	} fetch_state_t;

	// BTB counter geometry
	localparam int CNT_W = 2;
	localparam logic [CNT_W-1:0] CNT_MAX   = '1;
	localparam logic [CNT_W-1:0] CNT_MIN   = '0;
	localparam logic [CNT_W-1:0] CNT_ALLOC = 2'd2; // Weakly taken on allocation

endpackage

`default_nettype wire

//--- hdl/fetch_pc_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC generator
// Holds the fetch PC, the fetch FSM and the epoch bit.
// Issues memory requests under the queue credit rule and
// steers the next PC from the BTB prediction
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_gen import fetch_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire exception_event,
	input wire redirect_valid,
	input wire [ADDR_W-1:0] redirect_addr,
	input wire kernel_mode,
	input wire mem_req_ready,
	input wire queue_full,
	input wire pred_hit,
	input wire pred_taken,
	input wire [ADDR_W-1:0] pred_target,
	output wire [ADDR_W-1:0] lookup_pc,
	output wire mem_req_valid,
	output wire [ADDR_W-1:0] mem_req_addr,
	output wire mem_req_kernel,
	output wire push,
	output wire push_pred_taken,
	output wire [ADDR_W-1:0] push_pred_target,
	output wire epoch
);

	fetch_state_t state_q;
	logic [ADDR_W-1:0] pc_q;
	logic epoch_q;
	logic req_xfer;
	logic pred_use;
	logic [ADDR_W-1:0] pc_next;

	assign mem_req_valid = (state_q == FS_FETCH) && !queue_full;	// Credit rule
	assign req_xfer = mem_req_valid && mem_req_ready;

	// Lookup always runs on the current PC
	assign lookup_pc = pc_q;
	assign pred_use = pred_hit && pred_taken;
	assign pc_next = pred_use ? pred_target : pc_q + ADDR_W'(4);

	assign mem_req_addr = pc_q;
	assign mem_req_kernel = kernel_mode;

	// A request taken on a redirect edge keeps the old epoch and is dropped later
	assign push = req_xfer;
	assign push_pred_taken = pred_use;
	assign push_pred_target = pred_target;
	assign epoch = epoch_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= FS_START;
			pc_q <= RESET_PC;
			epoch_q <= 1'b0;
		end else if (redirect_valid) begin	// Wins over exception
			state_q <= FS_FETCH;
			pc_q <= {redirect_addr[ADDR_W-1:2], 2'b00};
			epoch_q <= !epoch_q;
		end else if (exception_event) begin
			state_q <= FS_HALT;
			epoch_q <= !epoch_q;
		end else begin
			case (state_q)
				FS_START: begin
					state_q <= FS_FETCH;
					pc_q <= RESET_PC;
				end
				FS_FETCH: begin
					if (req_xfer) begin
						pc_q <= pc_next;
					end
				end
				FS_HALT: begin
					state_q <= FS_HALT;	// Only a redirect leaves
				end
				default: begin
					state_q <= FS_START;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/fetch_addr_queue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Outstanding fetch address queue
// Show-ahead circular FIFO of issued requests with their kernel
// bit, prediction and epoch, paired in order with responses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module fetch_addr_queue import fetch_pkg::*; #(
	parameter int DEPTH = 8
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire push,
	input wire [ADDR_W-1:0] push_addr,
	input wire push_kernel,
	input wire push_pred_taken,
	input wire [ADDR_W-1:0] push_pred_target,
	input wire push_epoch,
	input wire pop,
	output wire full,
	output wire [ADDR_W-1:0] head_addr,
	output wire head_kernel,
	output wire head_pred_taken,
	output wire [ADDR_W-1:0] head_pred_target,
	output wire head_epoch
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int LVL_W = $clog2(DEPTH + 1);
	localparam int ENTRY_W = 2 * ADDR_W + 3;

	logic [ENTRY_W-1:0] mem_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [LVL_W-1:0] count_q;

	assign full = (count_q == LVL_W'(DEPTH));

	// Head is read straight from storage
	assign {head_epoch, head_kernel, head_pred_taken, head_pred_target, head_addr} =
		mem_q[rd_ptr_q];

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem_q[wr_ptr_q] <= {push_epoch, push_kernel, push_pred_taken,
				push_pred_target, push_addr};
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;	// Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/branch_predictor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch target buffer
// Direct-mapped table of tag, target and 2-bit counter.
// Combinational lookup, clocked update from branch resolution
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module branch_predictor import fetch_pkg::*; #(
	parameter int ENTRIES = 16
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire [ADDR_W-1:0] lookup_pc,
	input wire upd_valid,
	input wire [ADDR_W-1:0] upd_pc,
	input wire [ADDR_W-1:0] upd_target,
	input wire upd_taken,
	output wire hit,
	output wire taken,
	output wire [ADDR_W-1:0] target
);

	localparam int IDX_W = $clog2(ENTRIES);
	localparam int TAG_W = ADDR_W - 2 - IDX_W;

	logic [ENTRIES-1:0] valid_q;
	logic [TAG_W-1:0] tag_q [ENTRIES];
	logic [ADDR_W-1:0] target_q [ENTRIES];
	logic [CNT_W-1:0] cnt_q [ENTRIES];

	logic [IDX_W-1:0] lk_idx;
	logic [TAG_W-1:0] lk_tag;
	logic [IDX_W-1:0] up_idx;
	logic [TAG_W-1:0] up_tag;
	logic up_hit;

	// Word index sits just above the byte offset
	assign lk_idx = lookup_pc[IDX_W+1:2];
	assign lk_tag = lookup_pc[ADDR_W-1:IDX_W+2];
	assign up_idx = upd_pc[IDX_W+1:2];
	assign up_tag = upd_pc[ADDR_W-1:IDX_W+2];

	assign hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
	assign taken = (cnt_q[lk_idx] >= CNT_ALLOC);	// Upper half of the counter
	assign target = target_q[lk_idx];

	assign up_hit = valid_q[up_idx] && (tag_q[up_idx] == up_tag);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= '0;
		end else if (upd_valid && !up_hit && upd_taken) begin
			valid_q[up_idx] <= 1'b1;	// Allocate
		end
	end

	// Table payload
	always_ff @(posedge iCLOCK) begin
		if (upd_valid) begin
			if (up_hit) begin
				if (upd_taken) begin
					target_q[up_idx] <= upd_target;
					if (cnt_q[up_idx] != CNT_MAX) begin
						cnt_q[up_idx] <= cnt_q[up_idx] + 1'b1;
					end
				end else if (cnt_q[up_idx] != CNT_MIN) begin
					cnt_q[up_idx] <= cnt_q[up_idx] - 1'b1;
				end
			end else if (upd_taken) begin
				tag_q[up_idx] <= up_tag;
				target_q[up_idx] <= upd_target;
				cnt_q[up_idx] <= CNT_ALLOC;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/fetch_out_buffer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch output buffer
// Pairs memory responses with the queue head, drops stale
// epochs and holds one instruction toward decode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module fetch_out_buffer import fetch_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire mem_rsp_valid,
	input wire [ADDR_W-1:0] mem_rsp_inst,
	input wire [ADDR_W-1:0] head_addr,
	input wire head_kernel,
	input wire head_pred_taken,
	input wire [ADDR_W-1:0] head_pred_target,
	input wire head_epoch,
	input wire epoch,
	input wire flush,
	input wire dec_ready,
	output wire mem_rsp_ready,
	output wire pop,
	output wire dec_valid,
	output wire [ADDR_W-1:0] dec_inst,
	output wire [ADDR_W-1:0] dec_pc,
	output wire dec_kernel,
	output wire dec_pred_taken,
	output wire [ADDR_W-1:0] dec_pred_target
);

	logic valid_q;
	logic [ADDR_W-1:0] inst_q;
	logic [ADDR_W-1:0] pc_q;
	logic kernel_q;
	logic pred_taken_q;
	logic [ADDR_W-1:0] pred_target_q;
	logic rsp_xfer;
	logic rsp_live;

	assign mem_rsp_ready = !valid_q || dec_ready;
	assign rsp_xfer = mem_rsp_valid && mem_rsp_ready;
	assign rsp_live = rsp_xfer && (head_epoch == epoch);	// Else stale, dropped
	assign pop = rsp_xfer;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			valid_q <= 1'b0;
		end else if (rsp_live) begin
			valid_q <= 1'b1;
		end else if (dec_ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (rsp_live) begin
			inst_q <= mem_rsp_inst;
			pc_q <= head_addr;
			kernel_q <= head_kernel;
			pred_taken_q <= head_pred_taken;
			pred_target_q <= head_pred_target;
		end
	end

	assign dec_valid = valid_q;
	assign dec_inst = inst_q;
	assign dec_pc = pc_q;
	assign dec_kernel = kernel_q;
	assign dec_pred_taken = pred_taken_q;
	assign dec_pred_target = pred_target_q;

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction fetch stage
// PC generation, outstanding address queue, branch target
// buffer and decode output buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 8,	// At least the memory's outstanding limit
	parameter int BTB_ENTRIES = 16	// Power of two
) (
	input wire iCLOCK,
	input wire inRESET,
	output wire mem_req_valid,
	output wire [ADDR_W-1:0] mem_req_addr,
	output wire mem_req_kernel,
	input wire mem_req_ready,
	input wire mem_rsp_valid,
	input wire [ADDR_W-1:0] mem_rsp_inst,
	output wire mem_rsp_ready,
	output wire dec_valid,
	output wire [ADDR_W-1:0] dec_inst,
	output wire [ADDR_W-1:0] dec_pc,
	output wire dec_kernel,
	output wire dec_pred_taken,
	output wire [ADDR_W-1:0] dec_pred_target,
	input wire dec_ready,
	input wire exception_event,
	input wire redirect_valid,
	input wire [ADDR_W-1:0] redirect_addr,
	input wire kernel_mode,
	input wire upd_valid,
	input wire [ADDR_W-1:0] upd_pc,
	input wire [ADDR_W-1:0] upd_target,
	input wire upd_taken
);

	wire [ADDR_W-1:0] lookup_pc;
	wire pred_hit;
	wire pred_taken;
	wire [ADDR_W-1:0] pred_target;
	wire push;
	wire push_pred_taken;
	wire [ADDR_W-1:0] push_pred_target;
	wire epoch;
	wire queue_full;
	wire pop;
	wire [ADDR_W-1:0] head_addr;
	wire head_kernel;
	wire head_pred_taken;
	wire [ADDR_W-1:0] head_pred_target;
	wire head_epoch;
	wire flush;

	assign flush = redirect_valid || exception_event;	// Clears the held decode entry

	fetch_pc_gen u_pc_gen (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.exception_event(exception_event),
		.redirect_valid(redirect_valid),
		.redirect_addr(redirect_addr),
		.kernel_mode(kernel_mode),
		.mem_req_ready(mem_req_ready),
		.queue_full(queue_full),
		.pred_hit(pred_hit),
		.pred_taken(pred_taken),
		.pred_target(pred_target),
		.lookup_pc(lookup_pc),
		.mem_req_valid(mem_req_valid),
		.mem_req_addr(mem_req_addr),
		.mem_req_kernel(mem_req_kernel),
		.push(push),
		.push_pred_taken(push_pred_taken),
		.push_pred_target(push_pred_target),
		.epoch(epoch)
	);

	// Request address and kernel bit go straight into the queue
	fetch_addr_queue #(
		.DEPTH(QUEUE_DEPTH)
	) u_addr_queue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.push(push),
		.push_addr(mem_req_addr),
		.push_kernel(mem_req_kernel),
		.push_pred_taken(push_pred_taken),
		.push_pred_target(push_pred_target),
		.push_epoch(epoch),
		.pop(pop),
		.full(queue_full),
		.head_addr(head_addr),
		.head_kernel(head_kernel),
		.head_pred_taken(head_pred_taken),
		.head_pred_target(head_pred_target),
		.head_epoch(head_epoch)
	);

	branch_predictor #(
		.ENTRIES(BTB_ENTRIES)
	) u_btb (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.lookup_pc(lookup_pc),
		.upd_valid(upd_valid),
		.upd_pc(upd_pc),
		.upd_target(upd_target),
		.upd_taken(upd_taken),
		.hit(pred_hit),
		.taken(pred_taken),
		.target(pred_target)
	);

	fetch_out_buffer u_out_buffer (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_inst(mem_rsp_inst),
		.head_addr(head_addr),
		.head_kernel(head_kernel),
		.head_pred_taken(head_pred_taken),
		.head_pred_target(head_pred_target),
		.head_epoch(head_epoch),
		.epoch(epoch),
		.flush(flush),
		.dec_ready(dec_ready),
		.mem_rsp_ready(mem_rsp_ready),
		.pop(pop),
		.dec_valid(dec_valid),
		.dec_inst(dec_inst),
		.dec_pc(dec_pc),
		.dec_kernel(dec_kernel),
		.dec_pred_taken(dec_pred_taken),
		.dec_pred_target(dec_pred_target)
	);

endmodule

`default_nettype wire

//--- sim/fetch_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage testbench
// Random memory latency, decode stalls, redirects, exceptions and
// branch updates, checked against a cycle model of the fetch rules
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module fetch_tb import fetch_pkg::*;;

	localparam int PERIOD = 8;
	localparam int QDEPTH = 8;
	localparam int BTB_N = 16;
	localparam int IDX_W = 4;
	localparam int TAG_W = ADDR_W - 2 - IDX_W;
	localparam int N_OUT = 2000;
	localparam int CYC_PER_OUT = 40;	// Generous for flushes and stalls

	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		logic kernel;
		logic taken;
		logic [ADDR_W-1:0] target;
		logic epoch;
	} req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [31:0] due;	// Cycle the response may appear
	} mem_t;

	logic iCLOCK;
	logic inRESET;
	logic mem_req_ready;
	logic mem_rsp_valid;
	logic [ADDR_W-1:0] mem_rsp_inst;
	logic dec_ready;
	logic exception_event;
	logic redirect_valid;
	logic [ADDR_W-1:0] redirect_addr;
	logic kernel_mode;
	logic upd_valid;
	logic [ADDR_W-1:0] upd_pc;
	logic [ADDR_W-1:0] upd_target;
	logic upd_taken;
	wire mem_req_valid;
	wire [ADDR_W-1:0] mem_req_addr;
	wire mem_req_kernel;
	wire mem_rsp_ready;
	wire dec_valid;
	wire [ADDR_W-1:0] dec_inst;
	wire [ADDR_W-1:0] dec_pc;
	wire dec_kernel;
	wire dec_pred_taken;
	wire [ADDR_W-1:0] dec_pred_target;

	// Reference model state
	fetch_state_t m_state = FS_START;
	logic [ADDR_W-1:0] m_pc = RESET_PC;
	logic m_epoch = 1'b0;
	logic m_out_valid = 1'b0;
	req_t m_out;
	req_t exp_q[$];	// Requests awaiting a response
	logic m_valid [BTB_N] = '{default: 1'b0};
	logic [TAG_W-1:0] m_tag [BTB_N];
	logic [ADDR_W-1:0] m_tgt [BTB_N];
	logic [1:0] m_cnt [BTB_N];

	mem_t mem_q[$];
	logic [31:0] cyc = '0;
	int n_out = 0;
	int halt_wait = 0;
	logic hold_chk = 1'b0;
	logic [98:0] held;

	fetch_top #(
		.QUEUE_DEPTH(QDEPTH),
		.BTB_ENTRIES(BTB_N)
	) UUT (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.mem_req_valid(mem_req_valid),
		.mem_req_addr(mem_req_addr),
		.mem_req_kernel(mem_req_kernel),
		.mem_req_ready(mem_req_ready),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_inst(mem_rsp_inst),
		.mem_rsp_ready(mem_rsp_ready),
		.dec_valid(dec_valid),
		.dec_inst(dec_inst),
		.dec_pc(dec_pc),
		.dec_kernel(dec_kernel),
		.dec_pred_taken(dec_pred_taken),
		.dec_pred_target(dec_pred_target),
		.dec_ready(dec_ready),
		.exception_event(exception_event),
		.redirect_valid(redirect_valid),
		.redirect_addr(redirect_addr),
		.kernel_mode(kernel_mode),
		.upd_valid(upd_valid),
		.upd_pc(upd_pc),
		.upd_target(upd_target),
		.upd_taken(upd_taken)
	);

	initial iCLOCK = 1'b0;
	always #(PERIOD / 2) iCLOCK = ~iCLOCK;

	// Instruction word stored at each address
	function automatic logic [ADDR_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
		return {a[15:0], ~a[31:16]} ^ 32'h3c5a_9e17;
	endfunction

	task automatic fail_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error: %s is %h, expected %h", name, got, exp);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic fail_text(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	// BTB rules applied to the model table
	task automatic btb_update();
		logic [IDX_W-1:0] i;
		logic hit;
		i = upd_pc[IDX_W+1:2];
		hit = m_valid[i] && (m_tag[i] == upd_pc[ADDR_W-1:IDX_W+2]);
		if (hit && upd_taken) begin
			m_tgt[i] = upd_target;
			if (m_cnt[i] != 2'd3) m_cnt[i] = m_cnt[i] + 2'd1;
		end else if (hit) begin
			if (m_cnt[i] != 2'd0) m_cnt[i] = m_cnt[i] - 2'd1;
		end else if (upd_taken) begin	// Allocate weakly taken
			m_valid[i] = 1'b1;
			m_tag[i] = upd_pc[ADDR_W-1:IDX_W+2];
			m_tgt[i] = upd_target;
			m_cnt[i] = 2'd2;
		end
	endtask

	// Runs at each rising edge on the values settled since the falling edge
	task automatic check_cycle();
		req_t e;
		req_t h;
		mem_t m;
		logic req_x;
		logic rsp_x;
		logic flush;
		logic exp_req_valid;
		logic exp_rsp_ready;
		logic [IDX_W-1:0] i;
		req_x = mem_req_valid && mem_req_ready;
		rsp_x = mem_rsp_valid && mem_rsp_ready;
		flush = redirect_valid || exception_event;
		exp_req_valid = (m_state == FS_FETCH) && (exp_q.size() < QDEPTH);
		exp_rsp_ready = !m_out_valid || dec_ready;
		assert (mem_req_valid == exp_req_valid)
			else fail_value("mem_req_valid", 32'(mem_req_valid), 32'(exp_req_valid));
		assert (mem_rsp_ready == exp_rsp_ready)
			else fail_value("mem_rsp_ready", 32'(mem_rsp_ready), 32'(exp_rsp_ready));
		assert (dec_valid == m_out_valid)
			else fail_value("dec_valid", 32'(dec_valid), 32'(m_out_valid));
		if (m_out_valid) begin
			assert (dec_pc == m_out.pc) else fail_value("dec_pc", dec_pc, m_out.pc);
			assert (dec_inst == mem_word(m_out.pc))
				else fail_value("dec_inst", dec_inst, mem_word(m_out.pc));
			assert (dec_kernel == m_out.kernel)
				else fail_value("dec_kernel", 32'(dec_kernel), 32'(m_out.kernel));
			assert (dec_pred_taken == m_out.taken)
				else fail_value("dec_pred_taken", 32'(dec_pred_taken), 32'(m_out.taken));
			if (m_out.taken) begin
				assert (dec_pred_target == m_out.target)
					else fail_value("dec_pred_target", dec_pred_target, m_out.target);
			end
		end
		if (hold_chk) begin
			assert (held === {dec_valid, dec_kernel, dec_pred_taken, dec_inst, dec_pc,
				dec_pred_target}) else fail_text("Decode outputs changed during a stall");
		end
		hold_chk = dec_valid && !dec_ready && !flush;
		held = {dec_valid, dec_kernel, dec_pred_taken, dec_inst, dec_pc, dec_pred_target};
		if (dec_valid && dec_ready) n_out++;

		if (req_x) begin
			assert (mem_req_addr == m_pc) else fail_value("mem_req_addr", mem_req_addr, m_pc);
			assert (mem_req_kernel == kernel_mode)
				else fail_value("mem_req_kernel", 32'(mem_req_kernel), 32'(kernel_mode));
			i = m_pc[IDX_W+1:2];
			e.pc = m_pc;
			e.kernel = kernel_mode;
			e.taken = m_valid[i] && (m_tag[i] == m_pc[ADDR_W-1:IDX_W+2]) && (m_cnt[i] >= 2'd2);
			e.target = m_tgt[i];
			e.epoch = m_epoch;
			exp_q.push_back(e);
			m.addr = mem_req_addr;
			m.due = cyc + 32'd1 + ($urandom % 4);
			mem_q.push_back(m);
		end
		if (rsp_x) begin
			h = exp_q.pop_front();
			m = mem_q.pop_front();
		end

		// A flush beats a live response in the output buffer
		if (flush) begin
			m_out_valid = 1'b0;
		end else if (rsp_x && (h.epoch == m_epoch)) begin
			m_out = h;
			m_out_valid = 1'b1;
		end else if (dec_ready) begin
			m_out_valid = 1'b0;
		end

		if (redirect_valid) begin
			m_state = FS_FETCH;
			m_pc = {redirect_addr[ADDR_W-1:2], 2'b00};
			m_epoch = !m_epoch;
		end else if (exception_event) begin
			m_state = FS_HALT;
			m_epoch = !m_epoch;
		end else if (m_state == FS_START) begin
			m_state = FS_FETCH;
		end else if (req_x) begin
			m_pc = e.taken ? e.target : m_pc + 32'd4;
		end
		if (upd_valid) btb_update();
		cyc = cyc + 32'd1;
	endtask

	always @(posedge iCLOCK) begin
		if (inRESET) check_cycle();
	end

	// New stimulus each falling edge
	task automatic drive_inputs();
		int unsigned pick;
		if ($urandom % 16 == 0) kernel_mode = ~kernel_mode;
		mem_req_ready = (mem_q.size() < QDEPTH) && ($urandom % 4 != 0);
		if ((mem_q.size() != 0) && (cyc >= mem_q[0].due)) begin
			mem_rsp_valid = 1'b1;
			mem_rsp_inst = mem_word(mem_q[0].addr);
		end else begin
			mem_rsp_valid = 1'b0;
			mem_rsp_inst = $urandom;
		end
		dec_ready = ($urandom % 3 != 0);
		redirect_valid = 1'b0;
		exception_event = 1'b0;
		if (halt_wait != 0) begin	// Restart after an exception
			halt_wait--;
			if (halt_wait == 0) begin
				redirect_valid = 1'b1;
				redirect_addr = $urandom & 32'h1ff;
			end
		end else begin
			pick = $urandom % 100;
			if (pick < 2) begin
				exception_event = 1'b1;
				halt_wait = 2 + int'($urandom % 6);
			end else if (pick < 4) begin
				redirect_valid = 1'b1;
				redirect_addr = $urandom & 32'h1ff;	// Low bits left unaligned
				exception_event = ($urandom % 4 == 0);	// Redirect has priority
			end
		end
		upd_valid = ($urandom % 8 == 0);
		upd_pc = $urandom & 32'hfc;
		upd_target = $urandom & 32'h1fc;
		upd_taken = ($urandom % 4 != 0);
	endtask

	initial begin
		void'($urandom(32'ha9aa_d973));
		inRESET = 1'b0;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp_inst = '0;
		dec_ready = 1'b0;
		exception_event = 1'b0;
		redirect_valid = 1'b0;
		redirect_addr = '0;
		kernel_mode = 1'b1;
		upd_valid = 1'b0;
		upd_pc = '0;
		upd_target = '0;
		upd_taken = 1'b0;
		repeat (5) @(negedge iCLOCK);
		inRESET = 1'b1;
		while (n_out < N_OUT) begin
			@(negedge iCLOCK);
			drive_inputs();
		end
		$display("Test passed");
		$finish;
	end

	initial begin
		#(N_OUT * CYC_PER_OUT * PERIOD);
		$display("Timeout: only %0d of %0d decode outputs arrived", n_out, N_OUT);
		$display("Test failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- files.f
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/fetch_addr_queue.sv
hdl/branch_predictor.sv
hdl/fetch_out_buffer.sv
hdl/fetch_top.sv
sim/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the fetch stage with its testbench under Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fetch_tb -f files.f -o fetch_tb_sim \
	&& ./obj_dir/fetch_tb_sim \
	|| { echo "Simulation did not complete successfully"; exit 1; }
